/* icmp_echo_assert.sv */
module icmp_echo_assert
  import icmp_net_pkg::*;
(
  input logic                 clk,
  input logic                 fsm_rst,
  input logic                 rx_ready,
  input logic [7:0]           tx_data,
  input logic                 tx_valid,
  input logic                 tx_last,
  input logic                 tx_ready,
  input logic [ip_addr_w-1:0] tx_dst_ip,
  input logic [ip_addr_w-1:0] tx_src_ip,
  input logic [ip_id_w-1:0]   tx_ip_id
);

  // A stalled byte keeps data and sideband until taken
  tx_hold_a: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data) && $stable(tx_last) &&
      $stable(tx_dst_ip) && $stable(tx_src_ip) && $stable(tx_ip_id))
    else $error("tx stream changed while stalled");

  rx_blocked_a: assert property (@(posedge clk) disable iff (fsm_rst) tx_valid |-> !rx_ready)
    else $error("rx_ready high while a reply is being sent");

  rst_idle_a: assert property (@(posedge clk) fsm_rst |=> !tx_valid)
    else $error("tx_valid high right after reset");

endmodule

bind icmp_echo_top icmp_echo_assert u_icmp_echo_assert (
  .clk       (clk),
  .fsm_rst   (fsm_rst),
  .rx_ready  (rx_ready),
  .tx_data   (tx_data),
  .tx_valid  (tx_valid),
  .tx_last   (tx_last),
  .tx_ready  (tx_ready),
  .tx_dst_ip (tx_dst_ip),
  .tx_src_ip (tx_src_ip),
  .tx_ip_id  (tx_ip_id)
);

/* icmp_echo_rx.sv */
module icmp_echo_rx
  import icmp_net_pkg::*;
  import icmp_msg_pkg::*;
(
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic [7:0]            rx_data,
  input  logic                  rx_valid,
  input  logic                  rx_last,
  output logic                  rx_ready,
  input  logic [ip_addr_w-1:0]  rx_src_ip,
  input  logic [ip_proto_w-1:0] rx_proto,
  input  logic [ip_id_w-1:0]    rx_ip_id,
  output logic                  wr_en,
  output logic [7:0]            wr_data,
  output logic                  commit,
  output logic                  discard,
  output logic                  start,
  output icmp_hdr_u             hdr,
  output logic [ip_addr_w-1:0]  src_ip,
  output logic [ip_id_w-1:0]    ip_id,
  output logic [pay_len_w-1:0]  pay_len,
  input  logic                  done
);

  logic [7:0]  cnt;                          // Bytes taken so far in this packet
  logic        too_long;
  logic        xfer;
  logic        in_hdr;
  logic        pay_full;
  logic        accept;
  logic [16:0] chsum_sum;

  assign xfer     = rx_valid && rx_ready;
  assign in_hdr   = cnt < 8'(icmp_hdr_len);
  assign pay_full = cnt >= 8'(icmp_hdr_len + payload_max);

  assign wr_en   = xfer && !in_hdr && !pay_full && !too_long;
  assign wr_data = rx_data;

  // Evaluated on the last byte, cnt is one less than the packet length
  assign accept = (rx_proto == ip_proto_icmp) &&
                  (cnt >= 8'(icmp_hdr_len - 1)) &&
                  !pay_full && !too_long &&
                  (hdr.fields.icmp_type == icmp_type_echo_req);

  assign chsum_sum = {1'b0, hdr.fields.icmp_chsum} + {1'b0, icmp_chsum_adj};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      rx_ready <= 1'b1;
      cnt      <= '0;
      too_long <= 1'b0;
      commit   <= 1'b0;
      discard  <= 1'b0;
      start    <= 1'b0;
    end else begin
      commit  <= 1'b0;
      discard <= 1'b0;
      start   <= 1'b0;
      if (done) rx_ready <= 1'b1;           // Reply gone, open the input again
      if (xfer) begin
        if (rx_last) begin
          cnt      <= '0;
          too_long <= 1'b0;
          if (accept) begin
            commit   <= 1'b1;
            start    <= 1'b1;
            rx_ready <= 1'b0;
          end else begin
            discard <= 1'b1;
          end
        end else begin
          cnt <= cnt + 8'd1;
          if (pay_full) too_long <= 1'b1;    // Sticky until end of packet
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer && in_hdr) hdr.bytes[3'(icmp_hdr_len - 1) - cnt[2:0]] <= rx_data;
    if (xfer && rx_last && accept) begin
      hdr.fields.icmp_type  <= icmp_type_echo_rep;
      hdr.fields.icmp_code  <= 8'd0;
      hdr.fields.icmp_chsum <= chsum_sum[15:0] + 16'(chsum_sum[16]); // End-around carry
      src_ip                <= rx_src_ip;
      ip_id                 <= rx_ip_id;
      pay_len               <= pay_len_w'(cnt - 8'(icmp_hdr_len - 1));
    end
  end

endmodule

/* icmp_echo_top.sv */
module icmp_echo_top
  import icmp_net_pkg::*;
  import icmp_msg_pkg::*;
(
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  logic [ip_addr_w-1:0]  dev_ip,
  input  logic [7:0]            rx_data,
  input  logic                  rx_valid,
  input  logic                  rx_last,
  output logic                  rx_ready,
  input  logic [ip_addr_w-1:0]  rx_src_ip,
  input  logic [ip_proto_w-1:0] rx_proto,
  input  logic [ip_id_w-1:0]    rx_ip_id,
  output logic [7:0]            tx_data,
  output logic                  tx_valid,
  output logic                  tx_last,
  input  logic                  tx_ready,
  output logic [ip_addr_w-1:0]  tx_dst_ip,
  output logic [ip_addr_w-1:0]  tx_src_ip,
  output logic [ip_id_w-1:0]    tx_ip_id
);

  logic                 wr_en;
  logic [7:0]           wr_data;
  logic                 commit;
  logic                 discard;
  logic                 start;
  icmp_hdr_u            hdr;
  logic [ip_addr_w-1:0] src_ip;
  logic [ip_id_w-1:0]   ip_id;
  logic [pay_len_w-1:0] pay_len;
  logic                 done;
  logic                 rd_en;
  logic [7:0]           rd_data;

  icmp_echo_rx u_icmp_echo_rx (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .rx_last   (rx_last),
    .rx_ready  (rx_ready),
    .rx_src_ip (rx_src_ip),
    .rx_proto  (rx_proto),
    .rx_ip_id  (rx_ip_id),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .commit    (commit),
    .discard   (discard),
    .start     (start),
    .hdr       (hdr),
    .src_ip    (src_ip),
    .ip_id     (ip_id),
    .pay_len   (pay_len),
    .done      (done)
  );

  icmp_payload_buf u_icmp_payload_buf (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr_en   (wr_en),
    .wr_data (wr_data),
    .commit  (commit),
    .discard (discard),
    .rd_en   (rd_en),
    .rd_data (rd_data)
  );

  icmp_echo_tx u_icmp_echo_tx (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .start     (start),
    .hdr       (hdr),
    .src_ip    (src_ip),
    .ip_id     (ip_id),
    .pay_len   (pay_len),
    .dev_ip    (dev_ip),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .done      (done),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_last   (tx_last),
    .tx_ready  (tx_ready),
    .tx_dst_ip (tx_dst_ip),
    .tx_src_ip (tx_src_ip),
    .tx_ip_id  (tx_ip_id)
  );

endmodule

/* icmp_echo_tx.sv */
module icmp_echo_tx
  import icmp_net_pkg::*;
  import icmp_msg_pkg::*;
(
  input  logic                 clk,
  input  logic                 fsm_rst,
  input  logic                 start,
  input  icmp_hdr_u            hdr,
  input  logic [ip_addr_w-1:0] src_ip,
  input  logic [ip_id_w-1:0]   ip_id,
  input  logic [pay_len_w-1:0] pay_len,
  input  logic [ip_addr_w-1:0] dev_ip,
  output logic                 rd_en,
  input  logic [7:0]           rd_data,
  output logic                 done,
  output logic [7:0]           tx_data,
  output logic                 tx_valid,
  output logic                 tx_last,
  input  logic                 tx_ready,
  output logic [ip_addr_w-1:0] tx_dst_ip,
  output logic [ip_addr_w-1:0] tx_src_ip,
  output logic [ip_id_w-1:0]   tx_ip_id
);

  icmp_hdr_u            hdr_sr;              // Header bytes still to send
  logic                 sending;
  logic [7:0]           out_cnt;             // Bytes loaded into the output register
  logic [7:0]           total;
  logic [pay_len_w-1:0] pay_len_q;
  logic [pay_len_w-1:0] rd_cnt;
  logic [7:0]           pf_data;
  logic                 pf_valid;
  logic                 rd_pend;             // rd_data valid this cycle
  logic                 in_hdr;
  logic                 have_pay;
  logic                 more_rd;
  logic                 ld;
  logic                 use_pay;
  logic                 last_xfer;
  logic [7:0]           next_byte;

  assign total     = 8'(icmp_hdr_len) + 8'(pay_len_q);
  assign in_hdr    = out_cnt < 8'(icmp_hdr_len);
  assign have_pay  = pf_valid || rd_pend;   // Never both at once
  assign ld        = sending && (out_cnt < total) && (in_hdr || have_pay) &&
                     (!tx_valid || tx_ready);
  assign use_pay   = ld && !in_hdr;
  assign more_rd   = sending && (rd_cnt < pay_len_q);
  assign rd_en     = more_rd && (!have_pay || use_pay); // Stay one byte ahead
  assign last_xfer = tx_valid && tx_ready && tx_last;
  assign next_byte = in_hdr  ? hdr_sr.bytes[icmp_hdr_len-1] :
                     rd_pend ? rd_data : pf_data;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      sending  <= 1'b0;
      out_cnt  <= '0;
      rd_cnt   <= '0;
      pf_valid <= 1'b0;
      rd_pend  <= 1'b0;
      tx_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      done    <= last_xfer;
      rd_pend <= rd_en;
      if (rd_en) rd_cnt <= rd_cnt + 1'b1;
      if (rd_pend && !use_pay) begin
        pf_valid <= 1'b1;                    // Park the read byte
      end else if (use_pay) begin
        pf_valid <= 1'b0;
      end
      if (ld) begin
        tx_valid <= 1'b1;
        out_cnt  <= out_cnt + 8'd1;
      end else if (tx_ready) begin
        tx_valid <= 1'b0;
      end
      if (start) begin
        sending <= 1'b1;
        out_cnt <= '0;
        rd_cnt  <= '0;
      end else if (last_xfer) begin
        sending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pend && !use_pay) pf_data <= rd_data;
    if (ld) begin
      tx_data <= next_byte;
      tx_last <= (out_cnt == total - 8'd1);
      if (in_hdr) hdr_sr.bytes <= {hdr_sr.bytes[icmp_hdr_len-2:0], 8'h00};
    end
    if (start) begin
      hdr_sr    <= hdr;
      pay_len_q <= pay_len;
      tx_dst_ip <= src_ip;                   // Back to the requester
      tx_src_ip <= dev_ip;
      tx_ip_id  <= ip_id;
    end
  end

endmodule

/* icmp_msg_pkg.sv */
package icmp_msg_pkg;

  localparam int icmp_hdr_len = 8;          // Bytes
  localparam int payload_max  = 64;         // Largest echo payload, also buffer depth
  localparam int buf_aw       = $clog2(payload_max);
  localparam int pay_len_w    = $clog2(payload_max + 1);

  localparam logic [7:0]  icmp_type_echo_req = 8'd8;
  localparam logic [7:0]  icmp_type_echo_rep = 8'd0;
  localparam logic [15:0] icmp_chsum_adj     = 16'h0800; // Type 8 -> 0 in the high byte

  typedef struct packed {
    logic [7:0]  icmp_type;
    logic [7:0]  icmp_code;
    logic [15:0] icmp_chsum;
    logic [15:0] icmp_id;
    logic [15:0] icmp_seq;
  } icmp_hdr_s;

  // bytes[7] is the first byte on the wire
  typedef union packed {
    logic [icmp_hdr_len-1:0][7:0] bytes;
    icmp_hdr_s                    fields;
  } icmp_hdr_u;

endpackage

/* icmp_net_pkg.sv */
package icmp_net_pkg;

  // IPv4 header field widths used on the sideband
  localparam int ip_addr_w  = 32;
  localparam int ip_id_w    = 16;
  localparam int ip_proto_w = 8;

  // Protocol number carried in the IPv4 header for ICMP
  localparam logic [ip_proto_w-1:0] ip_proto_icmp = 8'd1;

endpackage

/* icmp_payload_buf.sv */
module icmp_payload_buf
  import icmp_msg_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       wr_en,
  input  logic [7:0] wr_data,
  input  logic       commit,
  input  logic       discard,
  input  logic       rd_en,
  output logic [7:0] rd_data
);

  logic [7:0]      mem [payload_max];
  // Extra top bit tells a full store from an empty one
  logic [buf_aw:0] wr_ptr;
  logic [buf_aw:0] cmt_ptr;
  logic [buf_aw:0] rd_ptr;
  logic            rd_ok;

  assign rd_ok = rd_en && (rd_ptr != cmt_ptr);  // Only committed bytes are readable

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr  <= '0;
      cmt_ptr <= '0;
      rd_ptr  <= '0;
    end else begin
      if (discard) begin
        wr_ptr <= cmt_ptr;                   // Roll back the rejected packet
      end else if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (commit) cmt_ptr <= wr_ptr;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr[buf_aw-1:0]] <= wr_data;
    if (rd_ok) rd_data <= mem[rd_ptr[buf_aw-1:0]];
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_icmp_echo \
  -f sim.f -o sim_icmp_echo
./obj_dir/sim_icmp_echo | tee sim.log

if grep -qx "TEST PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* sim.f */
icmp_net_pkg.sv
icmp_msg_pkg.sv
icmp_echo_rx.sv
icmp_payload_buf.sv
icmp_echo_tx.sv
icmp_echo_top.sv
icmp_echo_assert.sv
tb_icmp_echo.sv

/* tb_icmp_echo.sv */
module tb_icmp_echo
  import icmp_net_pkg::*;
  import icmp_msg_pkg::*;
();

  localparam int n_pkts         = 200;
  localparam int max_len        = 80;
  localparam int timeout_cycles = n_pkts * (2 * (icmp_hdr_len + max_len) + 20);

  logic                  clk;
  logic                  fsm_rst;
  logic [ip_addr_w-1:0]  dev_ip;
  logic [7:0]            rx_data;
  logic                  rx_valid;
  logic                  rx_last;
  logic                  rx_ready;
  logic [ip_addr_w-1:0]  rx_src_ip;
  logic [ip_proto_w-1:0] rx_proto;
  logic [ip_id_w-1:0]    rx_ip_id;
  logic [7:0]            tx_data;
  logic                  tx_valid;
  logic                  tx_last;
  logic                  tx_ready;
  logic [ip_addr_w-1:0]  tx_dst_ip;
  logic [ip_addr_w-1:0]  tx_src_ip;
  logic [ip_id_w-1:0]    tx_ip_id;

  logic [31:0]           stim_state  = 32'd45207;
  logic [31:0]           ready_state = 32'd45207;
  int                    cycle_cnt   = 0;
  int                    n_replies   = 0;
  logic [7:0]            pkt_bytes [max_len];
  int                    pkt_len;
  logic [ip_proto_w-1:0] pkt_proto;
  logic [ip_addr_w-1:0]  pkt_src_ip;
  logic [ip_id_w-1:0]    pkt_ip_id;
  logic [8:0]            exp_byte_q [$];     // {last, data}
  logic [ip_addr_w-1:0]  exp_dst_q [$];
  logic [ip_id_w-1:0]    exp_id_q [$];
  logic [8:0]            exp_word;
  logic [ip_addr_w-1:0]  cur_dst;
  logic [ip_id_w-1:0]    cur_id;
  logic                  pkt_first   = 1'b1;

  icmp_echo_top u_icmp_echo_top (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] next_rand16();
    stim_state = lcg_step(stim_state);
    return stim_state[31:16];
  endfunction

  function automatic logic [15:0] ones_add16(input logic [15:0] a, input logic [15:0] b);
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + {15'd0, s[16]};        // End-around carry
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // Random packet, and the reply it should get if it is a good echo request
  task automatic make_packet();
    logic [15:0] r;
    icmp_hdr_u   h;
    logic [7:0]  b;
    r = next_rand16();
    pkt_proto = (r[2:0] != 3'd0) ? ip_proto_icmp : (r[3] ? 8'd6 : 8'd17);
    r = next_rand16();
    pkt_len = (r[2:0] == 3'd0) ? icmp_hdr_len : 1 + int'(r[15:3]) % max_len;
    for (int i = 0; i < max_len; i++) begin
      r = next_rand16();
      pkt_bytes[i] = r[7:0];
    end
    r = next_rand16();
    if (r % 5 != 0) pkt_bytes[0] = icmp_type_echo_req;
    pkt_src_ip[31:16] = next_rand16();
    pkt_src_ip[15:0]  = next_rand16();
    pkt_ip_id         = next_rand16();
    if (pkt_proto == ip_proto_icmp && pkt_len >= icmp_hdr_len &&
        pkt_len <= icmp_hdr_len + payload_max && pkt_bytes[0] == icmp_type_echo_req) begin
      for (int i = 0; i < icmp_hdr_len; i++) begin
        h.bytes[icmp_hdr_len-1-i] = pkt_bytes[i];
      end
      h.fields.icmp_type  = icmp_type_echo_rep;
      h.fields.icmp_code  = 8'd0;
      h.fields.icmp_chsum = ones_add16(h.fields.icmp_chsum, icmp_chsum_adj);
      for (int i = 0; i < pkt_len; i++) begin
        if (i < icmp_hdr_len) b = h.bytes[icmp_hdr_len-1-i];
        else b = pkt_bytes[i];
        exp_byte_q.push_back({i == pkt_len - 1, b});
      end
      exp_dst_q.push_back(pkt_src_ip);
      exp_id_q.push_back(pkt_ip_id);
      n_replies++;
    end
  endtask

  task automatic drive_packet();
    logic [15:0] r;
    rx_src_ip <= pkt_src_ip;
    rx_proto  <= pkt_proto;
    rx_ip_id  <= pkt_ip_id;
    for (int i = 0; i < pkt_len; i++) begin
      r = next_rand16();
      if (r[1:0] == 2'd0) begin             // Idle gap
        rx_valid <= 1'b0;
        @(posedge clk);
      end
      rx_valid <= 1'b1;
      rx_data  <= pkt_bytes[i];
      rx_last  <= (i == pkt_len - 1);
      @(posedge clk);
      while (!rx_ready)
        @(posedge clk);
    end
  endtask

  always @(posedge clk) begin
    ready_state = lcg_step(ready_state);
    tx_ready <= (ready_state[31:16] % 3) != 0;
  end

  always @(posedge clk) begin
    if (!fsm_rst && tx_valid && tx_ready) begin
      if (exp_byte_q.size() == 0) begin
        $display("Error at %0t: reply byte sent when no reply was expected", $time);
        $display("TEST FAIL");
        $fatal(1);
      end else begin
        if (pkt_first) begin
          cur_dst = exp_dst_q.pop_front();
          cur_id  = exp_id_q.pop_front();
        end
        exp_word = exp_byte_q.pop_front();
        check_value("tx_data", tx_data, exp_word[7:0]);
        check_value("tx_last", tx_last, exp_word[8]);
        check_value("tx_dst_ip", tx_dst_ip, cur_dst);
        check_value("tx_src_ip", tx_src_ip, dev_ip);
        check_value("tx_ip_id", tx_ip_id, cur_id);
        pkt_first = exp_word[8];
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Run timed out after %0d cycles, %0d reply bytes never arrived",
               cycle_cnt, exp_byte_q.size());
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  initial begin
    clk       = 1'b0;
    fsm_rst   = 1'b1;
    dev_ip    = 32'h0a00_0001;
    rx_data   = 8'd0;
    rx_valid  = 1'b0;
    rx_last   = 1'b0;
    rx_src_ip = '0;
    rx_proto  = '0;
    rx_ip_id  = '0;
    tx_ready  = 1'b0;
    repeat (10) @(posedge clk);
    fsm_rst <= 1'b0;
    for (int p = 0; p < n_pkts; p++) begin
      make_packet();
      drive_packet();
    end
    rx_valid <= 1'b0;
    while (exp_byte_q.size() != 0)
      @(posedge clk);
    repeat (50) @(posedge clk);              // Catch any stray output
    // Input open again and output idle once the last reply is gone
    check_value("rx_ready", rx_ready, 1'b1);
    check_value("tx_valid", tx_valid, 1'b0);
    $display("%0d of %0d packets answered", n_replies, n_pkts);
    $display("TEST PASS");
    $finish;
  end

endmodule
